/* Makefile */
# Verilator flow for the console testbench
TOP := tb_console

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f src.f --top-module $(TOP) -Mdir obj_dir

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

/* hdl/char_decoder.sv */
`default_nettype none

module char_decoder import console_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_char_req,
  input  char_t              i_char,
  input  logic [TAB_W-1:0]   i_tab_count,
  input  logic               i_alt_func_en,
  input  logic               i_clear_stb,
  output logic               o_char_ack,
  output logic               o_wr_idle,
  console_cmd_if.issuer      cmd
);

  typedef enum logic [1:0] {
    D_IDLE,      // Waiting for host byte or clear
    D_ISSUE,     // cmd.req high
    D_RELEASE,   // req dropped, wait for engine ack low
    D_HOST_ACK   // Host ack high until host drops req
  } dec_state_e;

  dec_state_e r_state;
  logic       r_clear_pend;  // Clear seen, not yet issued
  logic       r_is_clear;    // Transfer in flight is a clear
  cmd_op_e    w_op;
  logic       w_act;         // Byte changes the buffer

  // Byte classification
  always_comb begin
    w_op  = OP_GLYPH;
    w_act = 1'b1;
    if (!i_alt_func_en) begin  // Alt function forces glyph
      case (i_char)
        CH_BS:        w_op = OP_BACKSPACE;
        CH_HT:        w_op = OP_TAB;
        CH_LF, CH_CR: w_op = OP_NEWLINE;
        default:      w_act = (i_char > 8'h1f) && (i_char != CH_DEL);
      endcase
    end
  end

  // Nothing running, nothing queued
  assign o_wr_idle = (r_state == D_IDLE) && !r_clear_pend && !i_clear_stb && !i_char_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state      <= D_IDLE;
      r_clear_pend <= 1'b1;  // Buffer is blanked out of reset
      r_is_clear   <= 1'b0;
      cmd.req      <= 1'b0;
      o_char_ack   <= 1'b0;
    end else begin
      case (r_state)
        D_IDLE: begin
          if (r_clear_pend) begin  // Clear wins over a waiting byte
            r_clear_pend <= 1'b0;
            r_is_clear   <= 1'b1;
            cmd.req      <= 1'b1;
            r_state      <= D_ISSUE;
          end else if (i_char_req) begin
            r_is_clear <= 1'b0;
            if (w_act) begin
              cmd.req <= 1'b1;
              r_state <= D_ISSUE;
            end else begin
              o_char_ack <= 1'b1;  // Ignored code, ack at once
              r_state    <= D_HOST_ACK;
            end
          end
        end
        D_ISSUE: begin
          if (cmd.ack) begin
            cmd.req <= 1'b0;
            r_state <= D_RELEASE;
          end
        end
        D_RELEASE: begin
          if (!cmd.ack) begin
            if (r_is_clear) begin
              r_state <= D_IDLE;
            end else begin
              o_char_ack <= 1'b1;  // Relay completion to host
              r_state    <= D_HOST_ACK;
            end
          end
        end
        D_HOST_ACK: begin
          if (!i_char_req) begin
            o_char_ack <= 1'b0;
            r_state    <= D_IDLE;
          end
        end
        default: r_state <= D_IDLE;
      endcase
      if (i_clear_stb) r_clear_pend <= 1'b1;  // Pulse kept until served
    end
  end

  // Command payload, latched as req rises
  always_ff @(posedge clk) begin
    if (r_state == D_IDLE) begin
      if (r_clear_pend) begin
        cmd.op <= OP_CLEAR;
      end else if (i_char_req) begin
        cmd.op   <= w_op;
        cmd.ch   <= i_char;
        cmd.tabs <= i_tab_count;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/char_ram.sv */
`default_nettype none

module char_ram import console_pkg::*; #(
  parameter  int COLS      = 8,
  parameter  int BUF_LINES = 6,
  localparam int DEPTH     = BUF_LINES * COLS,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                clk,
  input  logic                i_we,
  input  logic [ADDR_W-1:0]   i_wr_addr,
  input  char_t               i_wr_data,
  input  logic [ADDR_W-1:0]   i_rd_addr,
  output char_t               o_rd_data
);

  char_t mem [DEPTH];  // Line-major, COLS cells per line

  always_ff @(posedge clk) begin
    if (i_we) mem[i_wr_addr] <= i_wr_data;
    o_rd_data <= mem[i_rd_addr];  // One cycle read latency
  end

endmodule

`default_nettype wire

/* hdl/console_cmd_if.sv */
`default_nettype none

// Four-phase command channel, decoder to write engine
interface console_cmd_if import console_pkg::*; ();

  logic               req;   // Held until ack seen
  logic               ack;   // Command fully written
  cmd_op_e            op;
  char_t              ch;    // Glyph for OP_GLYPH
  logic [TAB_W-1:0]   tabs;  // Blank count for OP_TAB

  modport issuer (
    output req, op, ch, tabs,
    input  ack
  );

  modport executor (
    input  req, op, ch, tabs,
    output ack
  );

endinterface

`default_nettype wire

/* hdl/console_pkg.sv */
`default_nettype none

package console_pkg;

  // One displayed character cell
  typedef logic [7:0] char_t;

  // Work items handed from the decoder to the write engine
  typedef enum logic [2:0] {
    OP_GLYPH     = 3'd0,  // Store byte at cursor
    OP_BACKSPACE = 3'd1,  // Step back, blank cell
    OP_NEWLINE   = 3'd2,  // Blank rest of line
    OP_TAB       = 3'd3,  // Run of blanks
    OP_CLEAR     = 3'd4   // Blank whole ring
  } cmd_op_e;

  // Control codes the console reacts to
  localparam char_t CH_BS    = 8'h08;
  localparam char_t CH_HT    = 8'h09;
  localparam char_t CH_LF    = 8'h0a;
  localparam char_t CH_CR    = 8'h0d;
  localparam char_t CH_DEL   = 8'h7f;  // Ignored like the low controls

  localparam char_t CH_BLANK = 8'h00;  // Empty cell

  // Tab run length field
  localparam int TAB_W = 3;

endpackage

`default_nettype wire

/* hdl/console_top.sv */
`default_nettype none

module console_top import console_pkg::*; #(
  parameter int COLS        = 8,
  parameter int ROWS        = 4,
  parameter int BUF_LINES   = 6,  // Must exceed ROWS
  parameter int FONT_HEIGHT = 2
) (
  input  logic               clk,
  input  logic               rst,
  // Host byte port
  input  logic               i_char_req,
  input  char_t              i_char,
  input  logic [TAB_W-1:0]   i_tab_count,
  input  logic               i_alt_func_en,
  output logic               o_char_ack,
  // Clear
  input  logic               i_clear_stb,
  output logic               o_wr_idle,
  // Frame readout
  input  logic               i_frame_stb,
  output logic               o_frame_busy,
  output char_t              o_char,
  output logic               o_char_valid,
  input  logic               i_char_ready
);

  localparam int LINE_W = $clog2(BUF_LINES);
  localparam int ADDR_W = $clog2(BUF_LINES * COLS);

  logic                w_we;
  logic [ADDR_W-1:0]   w_wr_addr;
  char_t               w_wr_data;
  logic [LINE_W-1:0]   w_frame_line;  // Scroll position to reader
  logic [ADDR_W-1:0]   w_rd_addr;
  char_t               w_rd_data;

  console_cmd_if cmd_bus ();

  char_decoder u_char_decoder (
    .clk, .rst,
    .i_char_req, .i_char, .i_tab_count, .i_alt_func_en, .i_clear_stb,
    .o_char_ack, .o_wr_idle,
    .cmd (cmd_bus.issuer)
  );

  write_engine #(.COLS(COLS), .ROWS(ROWS), .BUF_LINES(BUF_LINES)) u_write_engine (
    .clk, .rst,
    .cmd          (cmd_bus.executor),
    .o_we         (w_we),
    .o_wr_addr    (w_wr_addr),
    .o_wr_data    (w_wr_data),
    .o_frame_line (w_frame_line)
  );

  char_ram #(.COLS(COLS), .BUF_LINES(BUF_LINES)) u_char_ram (
    .clk,
    .i_we      (w_we),
    .i_wr_addr (w_wr_addr),
    .i_wr_data (w_wr_data),
    .i_rd_addr (w_rd_addr),
    .o_rd_data (w_rd_data)
  );

  frame_reader #(
    .COLS(COLS), .ROWS(ROWS), .BUF_LINES(BUF_LINES), .FONT_HEIGHT(FONT_HEIGHT)
  ) u_frame_reader (
    .clk, .rst,
    .i_frame_stb,
    .i_wr_idle    (o_wr_idle),
    .i_frame_line (w_frame_line),
    .i_rd_data    (w_rd_data),
    .i_char_ready,
    .o_rd_addr    (w_rd_addr),
    .o_char, .o_char_valid, .o_frame_busy
  );

endmodule

`default_nettype wire

/* hdl/frame_reader.sv */
`default_nettype none

module frame_reader import console_pkg::*; #(
  parameter  int COLS        = 8,
  parameter  int ROWS        = 4,
  parameter  int BUF_LINES   = 6,
  parameter  int FONT_HEIGHT = 2,
  localparam int LINE_W      = $clog2(BUF_LINES),
  localparam int ADDR_W      = $clog2(BUF_LINES * COLS)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_frame_stb,
  input  logic                i_wr_idle,
  input  logic [LINE_W-1:0]   i_frame_line,
  input  char_t               i_rd_data,
  input  logic                i_char_ready,
  output logic [ADDR_W-1:0]   o_rd_addr,
  output char_t               o_char,
  output logic                o_char_valid,
  output logic                o_frame_busy
);

  localparam int COL_W  = $clog2(COLS);
  localparam int SCAN_W = (FONT_HEIGHT > 1) ? $clog2(FONT_HEIGHT) : 1;
  localparam int ROW_W  = (ROWS > 1) ? $clog2(ROWS) : 1;

  typedef enum logic [1:0] {
    R_IDLE,   // No frame requested
    R_WAIT,   // Hold off while writes are pending
    R_PRIME,  // First RAM fetch in flight
    R_SCAN    // Streaming characters
  } rd_state_e;

  rd_state_e           r_state;
  logic [LINE_W-1:0]   r_line, w_nxt_line;  // Buffer line of current row
  logic [COL_W-1:0]    r_col, w_nxt_col;
  logic [SCAN_W-1:0]   r_scan, w_nxt_scan;  // Font scanline
  logic [ROW_W-1:0]    r_row, w_nxt_row;    // Visible row
  logic                r_all_issued;        // Last char moved to output
  logic                w_col_end, w_scan_end, w_last;
  logic                w_load;              // i_rd_data into output register

  assign w_col_end  = (r_col == COL_W'(COLS - 1));
  assign w_scan_end = (r_scan == SCAN_W'(FONT_HEIGHT - 1));
  assign w_last     = w_col_end && w_scan_end && (r_row == ROW_W'(ROWS - 1));
  assign w_load     = (r_state == R_SCAN) && !r_all_issued && (!o_char_valid || i_char_ready);

  // Next scan position, row replays per scanline
  always_comb begin
    w_nxt_col  = w_col_end ? '0 : r_col + 1'b1;
    w_nxt_scan = r_scan;
    w_nxt_row  = r_row;
    w_nxt_line = r_line;
    if (w_col_end) begin
      w_nxt_scan = w_scan_end ? '0 : r_scan + 1'b1;
      if (w_scan_end) begin
        w_nxt_row  = r_row + 1'b1;
        w_nxt_line = (r_line == LINE_W'(BUF_LINES - 1)) ? '0 : r_line + 1'b1;
      end
    end
  end

  // Fetch one ahead; a stall keeps the current address
  assign o_rd_addr = w_load ? ADDR_W'(w_nxt_line) * ADDR_W'(COLS) + ADDR_W'(w_nxt_col)
                            : ADDR_W'(r_line) * ADDR_W'(COLS) + ADDR_W'(r_col);

  assign o_frame_busy = (r_state != R_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state      <= R_IDLE;
      o_char_valid <= 1'b0;
      r_all_issued <= 1'b0;
      r_line       <= '0;
      r_col        <= '0;
      r_scan       <= '0;
      r_row        <= '0;
    end else begin
      case (r_state)
        R_IDLE: if (i_frame_stb) r_state <= R_WAIT;
        R_WAIT: begin
          if (i_wr_idle) begin  // Frame start now stable
            r_line       <= i_frame_line;
            r_col        <= '0;
            r_scan       <= '0;
            r_row        <= '0;
            r_all_issued <= 1'b0;
            r_state      <= R_PRIME;
          end
        end
        R_PRIME: r_state <= R_SCAN;
        R_SCAN: begin
          if (w_load) begin
            o_char_valid <= 1'b1;
            r_line       <= w_nxt_line;
            r_col        <= w_nxt_col;
            r_scan       <= w_nxt_scan;
            r_row        <= w_nxt_row;
            if (w_last) r_all_issued <= 1'b1;
          end else if (o_char_valid && i_char_ready) begin
            o_char_valid <= 1'b0;  // Final transfer taken
            r_state      <= R_IDLE;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_load) o_char <= i_rd_data;
  end

endmodule

`default_nettype wire

/* hdl/write_engine.sv */
`default_nettype none

module write_engine import console_pkg::*; #(
  parameter  int COLS      = 8,
  parameter  int ROWS      = 4,
  parameter  int BUF_LINES = 6,
  localparam int LINE_W    = $clog2(BUF_LINES),
  localparam int ADDR_W    = $clog2(BUF_LINES * COLS)
) (
  input  logic                clk,
  input  logic                rst,
  console_cmd_if.executor     cmd,
  output logic                o_we,
  output logic [ADDR_W-1:0]   o_wr_addr,
  output char_t               o_wr_data,
  output logic [LINE_W-1:0]   o_frame_line
);

  localparam int COL_W = $clog2(COLS);
  localparam int CNT_W = $clog2(BUF_LINES * COLS + 1);  // Room for a full clear

  typedef enum logic [1:0] {
    W_IDLE,  // Wait for cmd.req
    W_RUN,   // One cell per cycle
    W_ACK    // ack high until req drops
  } wr_state_e;

  wr_state_e           r_state;
  logic [LINE_W-1:0]   r_line;        // Cursor line in ring
  logic [COL_W-1:0]    r_col;         // Cursor column
  logic [LINE_W-1:0]   r_frame_line;  // First visible line
  logic [CNT_W-1:0]    r_count;       // Cells still to write
  logic [CNT_W-1:0]    w_cells;
  logic [LINE_W-1:0]   w_next_line;
  logic [LINE_W-1:0]   w_next_frame;
  logic [LINE_W:0]     w_next_dist;   // Next line minus frame line, mod ring

  // Cells a command touches
  always_comb begin
    case (cmd.op)
      OP_GLYPH:     w_cells = CNT_W'(1);
      OP_BACKSPACE: w_cells = (r_col == '0) ? '0 : CNT_W'(1);  // No-op at column 0
      OP_NEWLINE:   w_cells = CNT_W'(COLS) - CNT_W'(r_col);
      OP_TAB:       w_cells = CNT_W'(cmd.tabs);
      OP_CLEAR:     w_cells = CNT_W'(BUF_LINES * COLS);
      default:      w_cells = '0;
    endcase
  end

  // Ring arithmetic for line wrap and scroll
  assign w_next_line  = (r_line == LINE_W'(BUF_LINES - 1)) ? '0 : r_line + 1'b1;
  assign w_next_frame = (r_frame_line == LINE_W'(BUF_LINES - 1)) ? '0 : r_frame_line + 1'b1;
  always_comb begin
    if (w_next_line >= r_frame_line)
      w_next_dist = {1'b0, w_next_line} - {1'b0, r_frame_line};
    else
      w_next_dist = {1'b0, w_next_line} + (LINE_W + 1)'(BUF_LINES) - {1'b0, r_frame_line};
  end

  // Memory write straight from cursor
  assign o_we         = (r_state == W_RUN);
  assign o_wr_addr    = ADDR_W'(r_line) * ADDR_W'(COLS) + ADDR_W'(r_col);
  assign o_wr_data    = (cmd.op == OP_GLYPH) ? cmd.ch : CH_BLANK;
  assign o_frame_line = r_frame_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state      <= W_IDLE;
      cmd.ack      <= 1'b0;
      r_line       <= '0;
      r_col        <= '0;
      r_frame_line <= '0;
      r_count      <= '0;
    end else begin
      case (r_state)
        W_IDLE: begin
          if (cmd.req) begin
            r_count <= w_cells;
            if (cmd.op == OP_CLEAR) begin  // Home cursor, top of ring
              r_line       <= '0;
              r_col        <= '0;
              r_frame_line <= '0;
            end else if (cmd.op == OP_BACKSPACE && r_col != '0) begin
              r_col <= r_col - 1'b1;  // Step back before blanking
            end
            if (w_cells == '0) begin
              cmd.ack <= 1'b1;
              r_state <= W_ACK;
            end else begin
              r_state <= W_RUN;
            end
          end
        end
        W_RUN: begin
          r_count <= r_count - 1'b1;
          if (cmd.op != OP_BACKSPACE) begin  // Backspace leaves cursor on blank
            if (r_col == COL_W'(COLS - 1)) begin
              r_col  <= '0;
              r_line <= w_next_line;
              // Scroll once the cursor leaves the screen
              if (cmd.op != OP_CLEAR && w_next_dist >= (LINE_W + 1)'(ROWS))
                r_frame_line <= w_next_frame;
            end else begin
              r_col <= r_col + 1'b1;
            end
          end
          if (r_count == CNT_W'(1)) begin  // Last cell written this edge
            cmd.ack <= 1'b1;
            r_state <= W_ACK;
          end
        end
        W_ACK: begin
          if (!cmd.req) begin
            cmd.ack <= 1'b0;
            r_state <= W_IDLE;
          end
        end
        default: r_state <= W_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+verif
hdl/console_pkg.sv
hdl/console_cmd_if.sv
hdl/char_decoder.sv
hdl/write_engine.sv
hdl/char_ram.sv
hdl/frame_reader.sv
hdl/console_top.sv
verif/tb_console.sv

/* verif/console_model.svh */
`ifndef CONSOLE_MODEL_SVH
`define CONSOLE_MODEL_SVH

// Expected buffer contents, line-major like the DUT memory
char_t ref_mem [BUF_LINES*COLS];
int    cur_line;  // Cursor line in ring
int    cur_col;
int    top_line;  // First visible line

// Whole ring blank, cursor home
function automatic void clear_buffer();
  foreach (ref_mem[i]) ref_mem[i] = CH_BLANK;
  cur_line = 0;
  cur_col  = 0;
  top_line = 0;
endfunction

// Write one cell and step right, wrap and scroll at line end
function automatic void put_cell(char_t ch);
  ref_mem[cur_line*COLS + cur_col] = ch;
  if (cur_col == COLS - 1) begin
    cur_col  = 0;
    cur_line = (cur_line + 1) % BUF_LINES;
    if ((cur_line - top_line + BUF_LINES) % BUF_LINES >= ROWS)
      top_line = (top_line + 1) % BUF_LINES;  // Cursor left the screen
  end else begin
    cur_col++;
  end
endfunction

// One host byte as the console should treat it
function automatic void apply_byte(char_t ch, int tabs, bit alt);
  int n;
  if (alt || (ch > 8'h1f && ch != CH_DEL)) begin
    put_cell(ch);
  end else if (ch == CH_BS) begin
    if (cur_col != 0) begin  // Nothing at column 0
      cur_col--;
      ref_mem[cur_line*COLS + cur_col] = CH_BLANK;
    end
  end else if (ch == CH_CR || ch == CH_LF) begin
    n = COLS - cur_col;  // Rest of line
    repeat (n) put_cell(CH_BLANK);
  end else if (ch == CH_HT) begin
    repeat (tabs) put_cell(CH_BLANK);
  end
endfunction

// Cell shown at a visible row and column
function automatic char_t expected_cell(int row, int col);
  return ref_mem[((top_line + row) % BUF_LINES)*COLS + col];
endfunction

`endif

/* verif/tb_console.sv */
`default_nettype none

module tb_console import console_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int COLS        = 8;
  localparam int ROWS        = 4;
  localparam int BUF_LINES   = 6;
  localparam int FONT_HEIGHT = 2;
  localparam int WAIT_LIMIT  = 200;   // Cycles per handshake phase
  localparam int FRAME_LIMIT = 5000;  // Cycles for a whole stalled frame

  logic             clk;
  logic             rst;
  logic             i_char_req;
  char_t            i_char;
  logic [TAB_W-1:0] i_tab_count;
  logic             i_alt_func_en;
  logic             o_char_ack;
  logic             i_clear_stb;
  logic             o_wr_idle;
  logic             i_frame_stb;
  logic             o_frame_busy;
  char_t            o_char;
  logic             o_char_valid;
  logic             i_char_ready;

  int          checks;
  int          errors;
  int          tests_run;
  logic [31:0] rng_state;
  char_t       frame_q [$];  // Characters taken in one readout

  `include "console_model.svh"

  console_top #(
    .COLS(COLS), .ROWS(ROWS), .BUF_LINES(BUF_LINES), .FONT_HEIGHT(FONT_HEIGHT)
  ) i_console_top (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic expect_eq(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic give_up(string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    $display("test %0d %-24s %0d errors", tests_run, name, errors - errs_before);
  endtask

  // Four-phase byte transfer, model updated once ack completes
  task automatic send_char(char_t ch, int tabs, bit alt);
    int n;
    @(negedge clk);
    i_char        = ch;
    i_tab_count   = TAB_W'(tabs);
    i_alt_func_en = alt;
    i_char_req    = 1'b1;
    n = 0;
    while (!o_char_ack) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) give_up("o_char_ack to rise");
    end
    i_char_req = 1'b0;
    n = 0;
    while (o_char_ack) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) give_up("o_char_ack to fall");
    end
    apply_byte(ch, tabs, alt);
  endtask

  task automatic send_text(string s, bit alt);
    for (int i = 0; i < s.len(); i++) send_char(s[i], 0, alt);
  endtask

  task automatic pulse_clear();
    int n;
    @(negedge clk);
    i_clear_stb = 1'b1;
    @(negedge clk);
    i_clear_stb = 1'b0;
    n = 0;
    while (!o_wr_idle) begin  // Clear runs one cell per cycle
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) give_up("o_wr_idle after clear");
    end
    clear_buffer();
  endtask

  // Collect one frame with random stalls on i_char_ready
  task automatic read_frame(int stall_pct);
    int    n;
    bit    held;
    char_t held_ch;
    frame_q.delete();
    held = 1'b0;
    held_ch = CH_BLANK;
    n = 0;
    while (o_frame_busy) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) give_up("o_frame_busy to fall before a frame");
    end
    @(negedge clk);
    i_frame_stb = 1'b1;
    @(negedge clk);
    i_frame_stb = 1'b0;
    n = 0;
    while (o_frame_busy) begin
      if (held) begin  // Stalled output must not move
        expect_eq(o_char_valid, 1, "o_char_valid under stall");
        expect_eq(o_char, held_ch, "o_char under stall");
      end
      i_char_ready = (next_rand() % 100) >= stall_pct;
      held    = o_char_valid && !i_char_ready;
      held_ch = o_char;
      if (o_char_valid && i_char_ready) frame_q.push_back(o_char);  // Taken next edge
      @(negedge clk);
      n++;
      if (n > FRAME_LIMIT) give_up("the frame readout to finish");
    end
    i_char_ready = 1'b0;
  endtask

  // Whole frame against the model, rows replayed per scanline
  task automatic check_frame();
    int row;
    int scan;
    int col;
    expect_eq(frame_q.size(), ROWS*FONT_HEIGHT*COLS, "frame length");
    foreach (frame_q[k]) begin
      row  = k / (FONT_HEIGHT*COLS);
      scan = (k / COLS) % FONT_HEIGHT;
      col  = k % COLS;
      expect_eq(frame_q[k], expected_cell(row, col),
                $sformatf("row %0d scan %0d col %0d", row, scan, col));
    end
  endtask

  task automatic reset_blank_frame();
    int e0;
    int n;
    e0 = errors;
    expect_eq(o_char_ack, 0, "o_char_ack after reset");
    expect_eq(o_char_valid, 0, "o_char_valid after reset");
    expect_eq(o_frame_busy, 0, "o_frame_busy after reset");
    expect_eq(o_wr_idle, 0, "o_wr_idle during reset clear");
    n = 0;
    while (!o_wr_idle) begin  // Reset clear still running
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) give_up("o_wr_idle after reset");
    end
    clear_buffer();
    read_frame(25);
    expect_eq(frame_q.size(), 64, "transfers after reset");
    foreach (frame_q[k]) expect_eq(frame_q[k], CH_BLANK, "blank cell after reset");
    report_test("reset state", e0);
  endtask

  task automatic hello_scanlines();
    int    e0;
    string s;
    e0 = errors;
    s = "HELLO";
    send_text(s, 1'b0);
    read_frame(25);
    check_frame();
    for (int c = 0; c < s.len(); c++) begin  // Same text on both scanlines
      expect_eq(frame_q[c], s[c], "row 0 scanline 0 text");
      expect_eq(frame_q[COLS + c], s[c], "row 0 scanline 1 text");
    end
    report_test("glyphs and scanlines", e0);
  endtask

  task automatic control_code_mix();
    int e0;
    e0 = errors;
    pulse_clear();
    send_char(CH_BS, 0, 1'b0);  // Column 0, no effect
    send_text("ab", 1'b0);
    send_char(CH_BS, 0, 1'b0);
    send_text("c", 1'b0);
    send_char(CH_HT, 3, 1'b0);
    send_text("x", 1'b0);
    send_char(CH_CR, 0, 1'b0);
    send_text("yz", 1'b0);
    send_char(CH_LF, 0, 1'b0);
    send_char(CH_HT, 0, 1'b0);  // Empty run
    send_char(CH_HT, 7, 1'b0);
    send_char(8'h01, 0, 1'b0);  // Unhandled codes
    send_char(CH_DEL, 0, 1'b0);
    send_text("q", 1'b0);
    read_frame(25);
    check_frame();
    report_test("backspace newline tab", e0);
  endtask

  task automatic scroll_ring_wrap();
    int    e0;
    string s;
    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 9; i++) begin  // More lines than the ring holds
      send_text($sformatf("ln%0d", i), 1'b0);
      send_char((i % 2) ? CH_LF : CH_CR, 0, 1'b0);
    end
    send_text("0123456789ab", 1'b0);  // Wraps into the next line
    read_frame(25);
    check_frame();
    s = "ln7";  // Oldest of the last four lines
    for (int c = 0; c < s.len(); c++) expect_eq(frame_q[c], s[c], "row 0 after scroll");
    report_test("scroll and ring wrap", e0);
  endtask

  task automatic clear_then_alt();
    int e0;
    e0 = errors;
    send_text("junk", 1'b0);
    pulse_clear();
    read_frame(25);
    foreach (frame_q[k]) expect_eq(frame_q[k], CH_BLANK, "blank cell after clear");
    check_frame();
    send_char(CH_BS, 0, 1'b1);
    send_char(CH_HT, 3, 1'b1);  // Tab count ignored
    send_char(CH_LF, 0, 1'b1);
    send_char(CH_CR, 0, 1'b1);
    send_char(8'h01, 0, 1'b1);
    send_char(CH_DEL, 0, 1'b1);
    read_frame(25);
    check_frame();
    expect_eq(frame_q[0], CH_BS, "backspace shown as glyph");
    report_test("clear and alt function", e0);
  endtask

  task automatic stalled_readout();
    int e0;
    e0 = errors;
    pulse_clear();
    for (int i = 0; i < 32; i++) send_char(char_t'(8'h21 + i), 0, 1'b0);  // Distinct cells
    read_frame(70);
    check_frame();
    report_test("back-pressure", e0);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    i_char_req    = 1'b0;
    i_char        = CH_BLANK;
    i_tab_count   = '0;
    i_alt_func_en = 1'b0;
    i_clear_stb   = 1'b0;
    i_frame_stb   = 1'b0;
    i_char_ready  = 1'b0;
    checks        = 0;
    errors        = 0;
    tests_run     = 0;
    rng_state     = 32'h0f4d_caeb;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    reset_blank_frame();
    hello_scanlines();
    control_code_mix();
    scroll_ring_wrap();
    clear_then_alt();
    stalled_readout();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
